// ==== Bender.yml ====
package:
  name: bouncy_ball

sources:
  - files:
      - common/pong_pkg.sv
      - common/object_pos_if.sv
      - hw/frame_sequencer.sv
      - hw/ball_motion.sv
      - hw/paddle_motion.sv
      - hw/pixel_writer.sv
      - hw/bouncy_ball_top.sv
  - target: test
    files:
      - dv/bouncy_ball_properties.sv
      - dv/frame_checker.sv
      - dv/tb_bouncy_ball.sv

// ==== common/object_pos_if.sv ====
`timescale 1ns/1ns

interface object_pos_if import pong_pkg::*; ();

    // Strobes from the frame sequencer
    logic   init;
    logic   update;

    // Object positions, top-left corner of each object
    coord_t ball_x;
    coord_t ball_y;
    coord_t paddle_x;

    modport seq (output init, output update);

    modport ball (input init, input update, output ball_x, output ball_y);

    modport paddle (input init, input update, output paddle_x);

    modport writer (input ball_x, input ball_y, input paddle_x);

endinterface

// ==== common/pong_pkg.sv ====
package pong_pkg;

    // Screen coordinate, shared by x and y
    typedef logic [7:0] coord_t;

    // One bit per channel, R G B
    typedef logic [2:0] colour_t;

    localparam colour_t COLOUR_BG     = 3'd0;
    localparam colour_t COLOUR_BALL   = 3'd7;
    localparam colour_t COLOUR_PADDLE = 3'd3;

    // Ball sprite is a 4x4 cell with the corners left out
    localparam int BALL_SIZE   = 4;
    localparam int BALL_PIXELS = 12;

    localparam int PADDLE_ROWS = 2;

    // Object currently being drawn
    typedef enum logic [1:0] {
        PH_NONE,
        PH_CLEAR,
        PH_BALL,
        PH_PADDLE
    } draw_phase_t;

    // Diagonal directions, clockwise from up-right
    typedef enum logic [1:0] {
        DIR_UP_RIGHT   = 2'd0,
        DIR_DOWN_RIGHT = 2'd1,
        DIR_DOWN_LEFT  = 2'd2,
        DIR_UP_LEFT    = 2'd3
    } ball_dir_t;

    typedef enum logic [2:0] {
        S_INIT,
        S_CLEAR,
        S_BALL,
        S_PADDLE,
        S_WAIT,
        S_UPDATE
    } seq_state_t;

endpackage

// ==== dv/bouncy_ball_properties.sv ====
`timescale 1ns/1ns

module bouncy_ball_properties import pong_pkg::*; #(
    parameter int SCREEN_W = 160,
    parameter int SCREEN_H = 120,
    parameter int PADDLE_W = 18
) (
    input logic   clk,
    input logic   resetn,
    input logic   plot,
    input coord_t pix_x,
    input coord_t pix_y,
    input logic   update,
    input coord_t paddle_x
);

    // Count of failed assertions
    int fail_count = 0;

    // Synchronous reset clears plot one edge into reset
    plot_low_in_reset: assert property (@(posedge clk) !resetn |=> !plot)
        else begin
            fail_count++;
            $error("plot high while reset is asserted");
        end

    pixel_on_screen: assert property (@(posedge clk) disable iff (!resetn)
        plot |-> (pix_x < SCREEN_W && pix_y < SCREEN_H))
        else begin
            fail_count++;
            $error("plotted pixel outside the screen");
        end

    paddle_in_range: assert property (@(posedge clk) disable iff (!resetn)
        paddle_x <= SCREEN_W - PADDLE_W)
        else begin
            fail_count++;
            $error("paddle position beyond the right limit");
        end

    update_one_cycle: assert property (@(posedge clk) disable iff (!resetn)
        update |=> !update)
        else begin
            fail_count++;
            $error("update strobe longer than one cycle");
        end

    no_plot_after_update: assert property (@(posedge clk) disable iff (!resetn)
        update |=> !plot)
        else begin
            fail_count++;
            $error("plot high in the cycle after the update");
        end

endmodule

// ==== dv/frame_checker.sv ====
`timescale 1ns/1ns

module frame_checker import pong_pkg::*; #(
    parameter int SCREEN_W    = 160,
    parameter int SCREEN_H    = 120,
    parameter int PADDLE_W    = 18,
    parameter int WAIT_CYCLES = 12500000
) (
    input  logic    clk,
    input  logic    resetn,
    input  logic    plot,
    input  coord_t  pix_x,
    input  coord_t  pix_y,
    input  colour_t colour,
    input  logic    move_left,
    input  logic    move_right,
    output int      error_count,
    output int      frame_count
);

    localparam int CLEAR_N = SCREEN_W * SCREEN_H;
    localparam int FRAME_N = CLEAR_N + BALL_PIXELS + 2 * PADDLE_W;

    // Game state of the model
    int   ball_x;
    int   ball_y;
    int   dir_x;
    int   dir_y;
    int   paddle_x;
    int   pix_idx;
    int   idle_cnt;
    logic key_left;
    logic key_right;
    int   sprite_dx[$];
    int   sprite_dy[$];

    // Sprite offsets in row-major order over the 4x4 cell without its corners
    initial begin
        for (int oy = 0; oy < BALL_SIZE; oy++) begin
            for (int ox = 0; ox < BALL_SIZE; ox++) begin
                if (!((ox == 0 || ox == BALL_SIZE - 1) &&
                      (oy == 0 || oy == BALL_SIZE - 1))) begin
                    sprite_dx.push_back(ox);
                    sprite_dy.push_back(oy);
                end
            end
        end
    end

    task automatic expected_pixel(input int idx, output int ex, output int ey,
                                  output colour_t ec);
        int k;
        if (idx < CLEAR_N) begin
            ex = idx % SCREEN_W;
            ey = idx / SCREEN_W;
            ec = COLOUR_BG;
        end else if (idx < CLEAR_N + BALL_PIXELS) begin
            k  = idx - CLEAR_N;
            ex = ball_x + sprite_dx[k];
            ey = ball_y + sprite_dy[k];
            ec = COLOUR_BALL;
        end else begin
            k  = idx - CLEAR_N - BALL_PIXELS;
            ex = paddle_x + (k % PADDLE_W);
            ey = SCREEN_H - 1 - (k / PADDLE_W);
            ec = COLOUR_PADDLE;
        end
    endtask

    task automatic update_model();
        // Reflect off the edges and then step diagonally
        if (ball_x == 0 && dir_x < 0) begin
            dir_x = 1;
        end else if (ball_x == SCREEN_W - 4 && dir_x > 0) begin
            dir_x = -1;
        end
        if (ball_y == 0 && dir_y < 0) begin
            dir_y = 1;
        end else if (ball_y == SCREEN_H - 6 && dir_y > 0) begin
            dir_y = -1;
        end
        ball_x = ball_x + dir_x;
        ball_y = ball_y + dir_y;
        if (key_left && paddle_x > 0) begin
            paddle_x = paddle_x - 1;
        end else if (key_right && paddle_x < SCREEN_W - PADDLE_W) begin
            paddle_x = paddle_x + 1;
        end
    endtask

    always @(negedge clk) begin
        int      ex;
        int      ey;
        colour_t ec;
        if (!resetn) begin
            ball_x   = 0;
            ball_y   = 0;
            dir_x    = 1;
            dir_y    = 1;
            paddle_x = 0;
            pix_idx  = 0;
            idle_cnt = 0;
        end else if (plot) begin
            // Wait and update cycles between two frames
            if (pix_idx == 0 && frame_count > 0 && idle_cnt != WAIT_CYCLES + 1) begin
                $display("Mismatch at %0t: frame %0d after %0d idle cycles, expected %0d",
                         $time, frame_count, idle_cnt, WAIT_CYCLES + 1);
                error_count++;
            end
            idle_cnt = 0;
            expected_pixel(pix_idx, ex, ey, ec);
            if (pix_x != ex || pix_y != ey || colour != ec) begin
                $display("Mismatch at %0t: frame %0d pixel %0d got (%0d,%0d) colour %0d",
                         $time, frame_count, pix_idx, pix_x, pix_y, colour);
                $display("    expected (%0d,%0d) colour %0d", ex, ey, ec);
                error_count++;
            end
            // Keys change with pixel 0 and hold until the update
            if (pix_idx == 1) begin
                key_left  = move_left;
                key_right = move_right;
            end
            if (pix_idx == FRAME_N - 1) begin
                update_model();
                frame_count++;
                pix_idx = 0;
            end else begin
                pix_idx++;
            end
        end else begin
            if (pix_idx != 0) begin
                $display("Mismatch at %0t: frame %0d has a gap before pixel %0d",
                         $time, frame_count, pix_idx);
                error_count++;
            end
            idle_cnt++;
        end
    end

endmodule

// ==== dv/tb_bouncy_ball.sv ====
`timescale 1ns/1ns

module tb_bouncy_ball import pong_pkg::*; ();

    localparam int SCREEN_W    = 16;
    localparam int SCREEN_H    = 12;
    localparam int PADDLE_W    = 6;
    localparam int WAIT_CYCLES = 5;
    localparam int NUM_FRAMES  = 40;

    // Draw, wait and update cycles of one frame
    localparam int FRAME_CYCLES = SCREEN_W * SCREEN_H + BALL_PIXELS + 2 * PADDLE_W
                                  + WAIT_CYCLES + 1;
    localparam longint TIMEOUT_NS = 2 * NUM_FRAMES * (FRAME_CYCLES + 8) * 8;

    logic        clk = 1'b0;
    logic        resetn;
    logic        move_left;
    logic        move_right;
    logic        plot;
    coord_t      pix_x;
    coord_t      pix_y;
    colour_t     colour;
    int          error_count;
    int          frame_count;
    int          assert_fails;
    logic [31:0] lfsr = 32'd71823;

    always #4 clk = ~clk;

    bouncy_ball_top #(
        .SCREEN_W    (SCREEN_W),
        .SCREEN_H    (SCREEN_H),
        .PADDLE_W    (PADDLE_W),
        .WAIT_CYCLES (WAIT_CYCLES)
    ) u_bouncy_ball_top (
        .clk        (clk),
        .resetn     (resetn),
        .move_left  (move_left),
        .move_right (move_right),
        .plot       (plot),
        .pix_x      (pix_x),
        .pix_y      (pix_y),
        .colour     (colour)
    );

    frame_checker #(
        .SCREEN_W    (SCREEN_W),
        .SCREEN_H    (SCREEN_H),
        .PADDLE_W    (PADDLE_W),
        .WAIT_CYCLES (WAIT_CYCLES)
    ) u_frame_checker (
        .clk         (clk),
        .resetn      (resetn),
        .plot        (plot),
        .pix_x       (pix_x),
        .pix_y       (pix_y),
        .colour      (colour),
        .move_left   (move_left),
        .move_right  (move_right),
        .error_count (error_count),
        .frame_count (frame_count)
    );

    bind bouncy_ball_top bouncy_ball_properties #(
        .SCREEN_W (SCREEN_W),
        .SCREEN_H (SCREEN_H),
        .PADDLE_W (PADDLE_W)
    ) u_bouncy_ball_properties (
        .clk      (clk),
        .resetn   (resetn),
        .plot     (plot),
        .pix_x    (pix_x),
        .pix_y    (pix_y),
        .update   (u_pos_if.update),
        .paddle_x (u_pos_if.paddle_x)
    );

    // 32-bit Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // New keys once per frame as the clear starts at the top-left pixel
    always @(negedge clk) begin
        logic key_a;
        logic key_b;
        if (resetn && plot && pix_x == 8'd0 && pix_y == 8'd0 && colour == COLOUR_BG) begin
            lfsr = lfsr_next(lfsr);
            key_a = lfsr[0];
            lfsr = lfsr_next(lfsr);
            key_b = lfsr[0];
            // Leans right in the first half and left after so both clamps are hit
            if (frame_count < NUM_FRAMES / 2) begin
                move_left  <= key_a & key_b;
                move_right <= key_a | !key_b;
            end else begin
                move_left  <= key_a | !key_b;
                move_right <= key_a & key_b;
            end
        end
    end

    initial begin
        resetn     = 1'b0;
        move_left  = 1'b0;
        move_right = 1'b0;
        repeat (4) @(negedge clk);
        resetn = 1'b1;
        wait (frame_count >= NUM_FRAMES);
        @(negedge clk);
        assert_fails = u_bouncy_ball_top.u_bouncy_ball_properties.fail_count;
        $display("Frames checked: %0d, mismatches: %0d, assertion failures: %0d",
                 frame_count, error_count, assert_fails);
        if (error_count == 0 && assert_fails == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Run timed out after %0d of %0d frames", frame_count, NUM_FRAMES);
        $display("test failed");
        $finish;
    end

endmodule

// ==== filelist.f ====
common/pong_pkg.sv
common/object_pos_if.sv
hw/frame_sequencer.sv
hw/ball_motion.sv
hw/paddle_motion.sv
hw/pixel_writer.sv
hw/bouncy_ball_top.sv
dv/bouncy_ball_properties.sv
dv/frame_checker.sv
dv/tb_bouncy_ball.sv

// ==== hw/ball_motion.sv ====
`timescale 1ns/1ns

module ball_motion import pong_pkg::*; #(
    parameter int SCREEN_W = 160,
    parameter int SCREEN_H = 120
) (
    input  logic       clk,
    input  logic       resetn,
    object_pos_if.ball pos
);

    // Rightmost and lowest top-left corner, lowest keeps clear of the paddle rows
    localparam coord_t X_MAX = coord_t'(SCREEN_W - BALL_SIZE);
    localparam coord_t Y_MAX = coord_t'(SCREEN_H - BALL_SIZE - PADDLE_ROWS);

    ball_dir_t dir;
    ball_dir_t dir_next;
    logic      go_right;
    logic      go_down;
    coord_t    x_next;
    coord_t    y_next;

    // Reflect first, then step in the reflected direction
    always_comb begin
        go_right = (dir == DIR_UP_RIGHT) || (dir == DIR_DOWN_RIGHT);
        go_down  = (dir == DIR_DOWN_RIGHT) || (dir == DIR_DOWN_LEFT);

        if (pos.ball_x == 8'd0 && !go_right) begin
            go_right = 1'b1;
        end else if (pos.ball_x == X_MAX && go_right) begin
            go_right = 1'b0;
        end

        if (pos.ball_y == 8'd0 && !go_down) begin
            go_down = 1'b1;
        end else if (pos.ball_y == Y_MAX && go_down) begin
            go_down = 1'b0;
        end

        case ({go_down, go_right})
            2'b01:   dir_next = DIR_UP_RIGHT;
            2'b11:   dir_next = DIR_DOWN_RIGHT;
            2'b10:   dir_next = DIR_DOWN_LEFT;
            default: dir_next = DIR_UP_LEFT;
        endcase

        x_next = go_right ? pos.ball_x + 8'd1 : pos.ball_x - 8'd1;
        y_next = go_down  ? pos.ball_y + 8'd1 : pos.ball_y - 8'd1;
    end

    always_ff @(posedge clk) begin
        if (!resetn || pos.init) begin
            pos.ball_x <= '0;
            pos.ball_y <= '0;
            dir        <= DIR_DOWN_RIGHT;
        end else if (pos.update) begin
            pos.ball_x <= x_next;
            pos.ball_y <= y_next;
            dir        <= dir_next;
        end
    end

endmodule

// ==== hw/bouncy_ball_top.sv ====
`timescale 1ns/1ns

module bouncy_ball_top import pong_pkg::*; #(
    parameter int SCREEN_W    = 160,
    parameter int SCREEN_H    = 120,
    parameter int PADDLE_W    = 18,
    parameter int WAIT_CYCLES = 12500000
) (
    input  logic    clk,
    input  logic    resetn,
    input  logic    move_left,
    input  logic    move_right,
    output logic    plot,
    output coord_t  pix_x,
    output coord_t  pix_y,
    output colour_t colour
);

    draw_phase_t phase;
    coord_t      col;
    coord_t      row;

    object_pos_if u_pos_if ();

    frame_sequencer #(
        .SCREEN_W    (SCREEN_W),
        .SCREEN_H    (SCREEN_H),
        .PADDLE_W    (PADDLE_W),
        .WAIT_CYCLES (WAIT_CYCLES)
    ) u_frame_sequencer (
        .clk    (clk),
        .resetn (resetn),
        .pos    (u_pos_if.seq),
        .phase  (phase),
        .col    (col),
        .row    (row)
    );

    ball_motion #(
        .SCREEN_W (SCREEN_W),
        .SCREEN_H (SCREEN_H)
    ) u_ball_motion (
        .clk    (clk),
        .resetn (resetn),
        .pos    (u_pos_if.ball)
    );

    paddle_motion #(
        .SCREEN_W (SCREEN_W),
        .PADDLE_W (PADDLE_W)
    ) u_paddle_motion (
        .clk        (clk),
        .resetn     (resetn),
        .move_left  (move_left),
        .move_right (move_right),
        .pos        (u_pos_if.paddle)
    );

    pixel_writer #(
        .SCREEN_H (SCREEN_H)
    ) u_pixel_writer (
        .clk    (clk),
        .resetn (resetn),
        .phase  (phase),
        .col    (col),
        .row    (row),
        .pos    (u_pos_if.writer),
        .plot   (plot),
        .pix_x  (pix_x),
        .pix_y  (pix_y),
        .colour (colour)
    );

endmodule

// ==== hw/frame_sequencer.sv ====
`timescale 1ns/1ns

module frame_sequencer import pong_pkg::*; #(
    parameter int SCREEN_W    = 160,
    parameter int SCREEN_H    = 120,
    parameter int PADDLE_W    = 18,
    parameter int WAIT_CYCLES = 12500000
) (
    input  logic        clk,
    input  logic        resetn,
    object_pos_if.seq   pos,
    output draw_phase_t phase,
    output coord_t      col,
    output coord_t      row
);

    // Column counter doubles as the wait counter, so it may be wider than a coordinate
    localparam int CNT_W = (WAIT_CYCLES > 256) ? $clog2(WAIT_CYCLES) : 8;

    localparam logic [CNT_W-1:0] CLEAR_COL_LAST  = CNT_W'(SCREEN_W - 1);
    localparam logic [CNT_W-1:0] BALL_COL_LAST   = CNT_W'(BALL_PIXELS - 1);
    localparam logic [CNT_W-1:0] PADDLE_COL_LAST = CNT_W'(PADDLE_W - 1);
    localparam logic [CNT_W-1:0] WAIT_LAST       = CNT_W'(WAIT_CYCLES - 1);
    localparam coord_t           CLEAR_ROW_LAST  = coord_t'(SCREEN_H - 1);
    localparam coord_t           PADDLE_ROW_LAST = coord_t'(PADDLE_ROWS - 1);

    seq_state_t       state;
    logic [CNT_W-1:0] col_cnt;
    coord_t           row_cnt;

    // Each drawing state exits on its last count, counters come back at zero
    always_ff @(posedge clk) begin
        if (!resetn) begin
            state   <= S_INIT;
            col_cnt <= '0;
            row_cnt <= '0;
        end else begin
            case (state)
                S_INIT: begin
                    state   <= S_CLEAR;
                    col_cnt <= '0;
                    row_cnt <= '0;
                end
                S_CLEAR: begin
                    if (col_cnt == CLEAR_COL_LAST) begin
                        col_cnt <= '0;
                        if (row_cnt == CLEAR_ROW_LAST) begin
                            row_cnt <= '0;
                            state   <= S_BALL;
                        end else begin
                            row_cnt <= row_cnt + 8'd1;
                        end
                    end else begin
                        col_cnt <= col_cnt + 1'b1;
                    end
                end
                S_BALL: begin
                    if (col_cnt == BALL_COL_LAST) begin
                        col_cnt <= '0;
                        state   <= S_PADDLE;
                    end else begin
                        col_cnt <= col_cnt + 1'b1;
                    end
                end
                S_PADDLE: begin
                    if (col_cnt == PADDLE_COL_LAST) begin
                        col_cnt <= '0;
                        if (row_cnt == PADDLE_ROW_LAST) begin
                            row_cnt <= '0;
                            state   <= S_WAIT;
                        end else begin
                            row_cnt <= row_cnt + 8'd1;
                        end
                    end else begin
                        col_cnt <= col_cnt + 1'b1;
                    end
                end
                S_WAIT: begin
                    if (col_cnt == WAIT_LAST) begin
                        col_cnt <= '0;
                        state   <= S_UPDATE;
                    end else begin
                        col_cnt <= col_cnt + 1'b1;
                    end
                end
                S_UPDATE: begin
                    // Positions move here, next frame starts right after
                    state <= S_CLEAR;
                end
                default: begin
                    state <= S_INIT;
                end
            endcase
        end
    end

    always_comb begin
        case (state)
            S_CLEAR:  phase = PH_CLEAR;
            S_BALL:   phase = PH_BALL;
            S_PADDLE: phase = PH_PADDLE;
            default:  phase = PH_NONE;
        endcase
    end

    assign pos.init   = (state == S_INIT);
    assign pos.update = (state == S_UPDATE);

    assign col = col_cnt[7:0];
    assign row = row_cnt;

endmodule

// ==== hw/paddle_motion.sv ====
`timescale 1ns/1ns

module paddle_motion import pong_pkg::*; #(
    parameter int SCREEN_W = 160,
    parameter int PADDLE_W = 18
) (
    input  logic         clk,
    input  logic         resetn,
    input  logic         move_left,
    input  logic         move_right,
    object_pos_if.paddle pos
);

    localparam coord_t X_MAX = coord_t'(SCREEN_W - PADDLE_W);

    // One pixel per frame, left key has priority
    always_ff @(posedge clk) begin
        if (!resetn || pos.init) begin
            pos.paddle_x <= '0;
        end else if (pos.update) begin
            if (move_left && pos.paddle_x != 8'd0) begin
                pos.paddle_x <= pos.paddle_x - 8'd1;
            end else if (move_right && pos.paddle_x != X_MAX) begin
                pos.paddle_x <= pos.paddle_x + 8'd1;
            end
        end
    end

endmodule

// ==== hw/pixel_writer.sv ====
`timescale 1ns/1ns

module pixel_writer import pong_pkg::*; #(
    parameter int SCREEN_H = 120
) (
    input  logic         clk,
    input  logic         resetn,
    input  draw_phase_t  phase,
    input  coord_t       col,
    input  coord_t       row,
    object_pos_if.writer pos,
    output logic         plot,
    output coord_t       pix_x,
    output coord_t       pix_y,
    output colour_t      colour
);

    localparam coord_t Y_BOTTOM = coord_t'(SCREEN_H - 1);

    logic [1:0] off_x;
    logic [1:0] off_y;
    logic       plot_d;
    coord_t     x_d;
    coord_t     y_d;
    colour_t    colour_d;

    // Sprite index to cell offset, row-major, corners skipped
    always_comb begin
        case (col[3:0])
            4'd0:    {off_y, off_x} = {2'd0, 2'd1};
            4'd1:    {off_y, off_x} = {2'd0, 2'd2};
            4'd2:    {off_y, off_x} = {2'd1, 2'd0};
            4'd3:    {off_y, off_x} = {2'd1, 2'd1};
            4'd4:    {off_y, off_x} = {2'd1, 2'd2};
            4'd5:    {off_y, off_x} = {2'd1, 2'd3};
            4'd6:    {off_y, off_x} = {2'd2, 2'd0};
            4'd7:    {off_y, off_x} = {2'd2, 2'd1};
            4'd8:    {off_y, off_x} = {2'd2, 2'd2};
            4'd9:    {off_y, off_x} = {2'd2, 2'd3};
            4'd10:   {off_y, off_x} = {2'd3, 2'd1};
            default: {off_y, off_x} = {2'd3, 2'd2};
        endcase
    end

    always_comb begin
        plot_d   = 1'b1;
        x_d      = col;
        y_d      = row;
        colour_d = COLOUR_BG;
        case (phase)
            PH_CLEAR: begin
                colour_d = COLOUR_BG;
            end
            PH_BALL: begin
                x_d      = pos.ball_x + coord_t'(off_x);
                y_d      = pos.ball_y + coord_t'(off_y);
                colour_d = COLOUR_BALL;
            end
            PH_PADDLE: begin
                // Row 0 is the bottom line of the screen
                x_d      = pos.paddle_x + col;
                y_d      = Y_BOTTOM - row;
                colour_d = COLOUR_PADDLE;
            end
            default: begin
                plot_d = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            plot <= 1'b0;
        end else begin
            plot <= plot_d;
        end
    end

    always_ff @(posedge clk) begin
        pix_x  <= x_d;
        pix_y  <= y_d;
        colour <= colour_d;
    end

endmodule
